// File: logic/exe_isa_pkg.sv
package exe_isa_pkg;

	// integer ops, base register/immediate set
	typedef enum logic [3:0]
	{
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_op_t;

	// branch compare conditions
	typedef enum logic [2:0]
	{
		br_none = 3'd0, // not a branch
		br_eq   = 3'd1,
		br_ne   = 3'd2,
		br_lt   = 3'd3,
		br_ge   = 3'd4,
		br_ltu  = 3'd5,
		br_geu  = 3'd6
	} br_cond_t;

	// writeback source in stage 6
	typedef enum logic [1:0]
	{
		wb_alu      = 2'd0,
		wb_pc_plus4 = 2'd1, // link address for jal/jalr
		wb_lui      = 2'd2,
		wb_auipc    = 2'd3
	} wb_sel_t;

endpackage

// File: logic/exe_trap_pkg.sv
package exe_trap_pkg;

	// privilege levels, mstatus encoding
	typedef enum logic [1:0]
	{
		mode_user       = 2'd0,
		mode_supervisor = 2'd1,
		mode_reserved   = 2'd2,
		mode_machine    = 2'd3
	} priv_mode_t;

	// synchronous cause codes
	typedef enum logic [4:0]
	{
		exc_i_addr_misaligned = 5'd0,
		exc_i_illegal         = 5'd2,
		exc_breakpoint        = 5'd3,
		exc_u_call            = 5'd8,
		exc_s_call            = 5'd9,
		exc_m_call            = 5'd11
	} exc_code_t;

	// interrupt cause codes, msb of cause set on top of these
	typedef enum logic [4:0]
	{
		int_u_timer = 5'd4,
		int_s_timer = 5'd5,
		int_m_timer = 5'd7,
		int_u_ext   = 5'd8,
		int_s_ext   = 5'd9,
		int_m_ext   = 5'd11
	} int_code_t;

endpackage

// File: logic/issue_stage.sv
`timescale 1ns/10ps

module issue_stage #(parameter int xlen = 32)
(
	input  logic clk,
	input  logic nrst,
	input  logic flush,
	input  logic [xlen-1:0] op_a,
	input  logic [xlen-1:0] op_b,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] b_imm,
	input  logic [xlen-1:0] j_imm,
	input  logic [xlen-1:0] u_imm,
	input  logic [4:0] rd,
	input  logic we,
	input  logic j,
	input  logic jr,
	input  exe_isa_pkg::alu_op_t alu_op,
	input  exe_isa_pkg::br_cond_t br_cond,
	input  exe_isa_pkg::wb_sel_t wb_sel,
	input  logic instr_misaligned,
	input  logic ecall,
	input  logic ebreak,
	input  logic illegal,
	output logic [xlen-1:0] s5_op_a,
	output logic [xlen-1:0] s5_op_b,
	output logic [xlen-1:0] s5_pc,
	output logic [xlen-1:0] s5_b_imm,
	output logic [xlen-1:0] s5_j_imm,
	output logic [xlen-1:0] s5_u_imm,
	output logic [4:0] s5_rd,
	output logic s5_we,
	output logic s5_j,
	output logic s5_jr,
	output exe_isa_pkg::alu_op_t s5_alu_op,
	output exe_isa_pkg::br_cond_t s5_br_cond,
	output exe_isa_pkg::wb_sel_t s5_wb_sel,
	output logic s5_instr_misaligned,
	output logic s5_ecall,
	output logic s5_ebreak,
	output logic s5_illegal
);
	import exe_isa_pkg::*;

	logic jr_q;

	// control fields, cleared by reset and by a pending trap
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst || flush)
		begin
			s5_we <= 1'b0;
			s5_j <= 1'b0;
			jr_q <= 1'b0;
			s5_alu_op <= alu_add;
			s5_br_cond <= br_none;
			s5_wb_sel <= wb_alu;
			s5_instr_misaligned <= 1'b0;
			s5_ecall <= 1'b0;
			s5_ebreak <= 1'b0;
			s5_illegal <= 1'b0;
		end
		else
		begin
			s5_we <= we;
			s5_j <= j;
			jr_q <= jr;
			s5_alu_op <= alu_op;
			s5_br_cond <= br_cond;
			s5_wb_sel <= wb_sel;
			s5_instr_misaligned <= instr_misaligned;
			s5_ecall <= ecall;
			s5_ebreak <= ebreak;
			s5_illegal <= illegal;
		end
	end

	// operands and immediates
	always_ff @(posedge clk)
	begin
		if (flush)
		begin
			s5_op_a <= '0;
			s5_op_b <= '0;
			s5_pc <= '0;
			s5_b_imm <= '0;
			s5_j_imm <= '0;
			s5_u_imm <= '0;
			s5_rd <= '0;
		end
		else
		begin
			s5_op_a <= op_a;
			s5_op_b <= op_b;
			s5_pc <= pc;
			s5_b_imm <= b_imm;
			s5_j_imm <= j_imm;
			s5_u_imm <= u_imm;
			s5_rd <= rd;
		end
	end

	assign s5_jr = jr_q & ~jr; // held-over jr masked while issue repeats it

endmodule

// File: logic/alu.sv
`timescale 1ns/10ps

module alu #(parameter int xlen = 32)
(
	input  exe_isa_pkg::alu_op_t alu_op,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	output logic [xlen-1:0] result
);
	import exe_isa_pkg::*;

	localparam int shw = $clog2(xlen);

	logic [shw-1:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = b[shw-1:0]; // 5 bits on rv32, 6 on rv64
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb
	begin
		unique case (alu_op)
			alu_add:
				result = a + b;
			alu_sub:
				result = a - b;
			alu_sll:
				result = a << shamt;
			alu_slt:
				result = {{(xlen-1){1'b0}}, lt_signed};
			alu_sltu:
				result = {{(xlen-1){1'b0}}, lt_unsigned};
			alu_xor:
				result = a ^ b;
			alu_srl:
				result = a >> shamt;
			alu_sra:
				result = $unsigned($signed(a) >>> shamt); // keeps sign
			alu_or:
				result = a | b;
			alu_and:
				result = a & b;
			default:
				result = '0;
		endcase
	end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/10ps

module branch_unit #(parameter int xlen = 32)
(
	input  exe_isa_pkg::br_cond_t br_cond,
	input  logic j,
	input  logic jr,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  logic [xlen-1:0] b_imm,
	input  logic [xlen-1:0] j_imm,
	output logic [xlen-1:0] target,
	output logic redirect
);
	import exe_isa_pkg::*;

	logic taken;
	logic [xlen-1:0] jr_sum;

	always_comb
	begin
		unique case (br_cond)
			br_eq:   taken = (a == b);
			br_ne:   taken = (a != b);
			br_lt:   taken = ($signed(a) < $signed(b));
			br_ge:   taken = ($signed(a) >= $signed(b));
			br_ltu:  taken = (a < b);
			br_geu:  taken = (a >= b);
			default: taken = 1'b0; // br_none
		endcase
	end

	assign jr_sum = a + b; // rs1 + I-imm

	always_comb
	begin
		if (jr)
			target = {jr_sum[xlen-1:1], 1'b0};
		else if (j)
			target = pc + j_imm;
		else if (taken)
			target = pc + b_imm;
		else
			target = '0;
	end

	assign redirect = taken | j | jr;

endmodule

// File: logic/commit_stage.sv
`timescale 1ns/10ps

module commit_stage #(parameter int xlen = 32)
(
	input  logic clk,
	input  logic nrst,
	input  logic flush,
	input  logic [xlen-1:0] alu_result,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] u_imm,
	input  logic [4:0] rd,
	input  logic we,
	input  exe_isa_pkg::wb_sel_t wb_sel,
	input  logic s5_instr_misaligned,
	input  logic s5_ecall,
	input  logic s5_ebreak,
	input  logic s5_illegal,
	output logic [xlen-1:0] wb_data,
	output logic [xlen-1:0] pc_out,
	output logic [4:0] wb_rd,
	output logic wb_we,
	output logic f_misaligned,
	output logic f_ecall,
	output logic f_ebreak,
	output logic f_illegal
);
	import exe_isa_pkg::*;

	wb_sel_t s6_wb_sel;
	logic [xlen-1:0] s6_alu;
	logic [xlen-1:0] s6_u_imm;
	logic [xlen-1:0] s6_auipc;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst || flush)
		begin
			wb_we <= 1'b0;
			s6_wb_sel <= wb_alu;
			f_misaligned <= 1'b0;
			f_ecall <= 1'b0;
			f_ebreak <= 1'b0;
			f_illegal <= 1'b0;
		end
		else
		begin
			wb_we <= we;
			s6_wb_sel <= wb_sel;
			f_misaligned <= s5_instr_misaligned;
			f_ecall <= s5_ecall;
			f_ebreak <= s5_ebreak;
			f_illegal <= s5_illegal;
		end
	end

	// result payload, pc survives a flush
	always_ff @(posedge clk)
	begin
		if (flush)
		begin
			s6_alu <= '0;
			s6_u_imm <= '0;
			s6_auipc <= '0;
			wb_rd <= '0;
		end
		else
		begin
			s6_alu <= alu_result;
			s6_u_imm <= u_imm;
			s6_auipc <= u_imm + pc; // auipc sum formed ahead of the register
			wb_rd <= rd;
			pc_out <= pc;
		end
	end

	always_comb
	begin
		unique case (s6_wb_sel)
			wb_pc_plus4: wb_data = pc_out + xlen'(4);
			wb_lui:      wb_data = s6_u_imm;
			wb_auipc:    wb_data = s6_auipc;
			default:     wb_data = s6_alu;
		endcase
	end

endmodule

// File: logic/trap_unit.sv
`timescale 1ns/10ps

module trap_unit #(parameter int xlen = 32)
(
	input  logic f_misaligned,
	input  logic f_ecall,
	input  logic f_ebreak,
	input  logic f_illegal,
	input  exe_trap_pkg::priv_mode_t current_mode,
	input  logic m_timer,
	input  logic s_timer,
	input  logic u_timer,
	input  logic external_interrupt,
	input  logic m_tie,
	input  logic s_tie,
	input  logic u_tie,
	input  logic m_eie,
	input  logic s_eie,
	input  logic u_eie,
	output logic exception,
	output logic [xlen-1:0] cause,
	output logic m_interrupt,
	output logic s_interrupt,
	output logic u_interrupt
);
	import exe_trap_pkg::*;

	logic m_timer_c, s_timer_c, u_timer_c;
	logic below_m, in_user;
	logic irq;
	logic [4:0] code;

	assign below_m = (current_mode != mode_machine);
	assign in_user = (current_mode == mode_user);

	// M sources only need their enable
	assign m_timer_c = m_tie & m_timer;
	assign s_timer_c = below_m & s_tie & s_timer;
	assign u_timer_c = in_user & u_tie & u_timer;
	assign m_interrupt = m_eie & external_interrupt;
	assign s_interrupt = below_m & s_eie & external_interrupt;
	assign u_interrupt = in_user & u_eie & external_interrupt;

	assign exception = m_interrupt | s_interrupt | u_interrupt
		| m_timer_c | s_timer_c | u_timer_c
		| f_misaligned | f_illegal | f_ecall | f_ebreak;

	// first match wins, interrupts ahead of faults
	always_comb
	begin
		irq = 1'b1;
		code = '0;
		if (m_interrupt)
			code = int_m_ext;
		else if (s_interrupt)
			code = int_s_ext;
		else if (m_timer_c)
			code = int_m_timer;
		else if (s_timer_c)
			code = int_s_timer;
		else if (u_interrupt)
			code = int_u_ext;
		else if (u_timer_c)
			code = int_u_timer;
		else
		begin
			irq = 1'b0;
			if (f_misaligned)
				code = exc_i_addr_misaligned;
			else if (f_illegal)
				code = exc_i_illegal; // outranks ecall in the same instruction
			else if (f_ecall)
			begin
				unique case (current_mode)
					mode_user:       code = exc_u_call;
					mode_supervisor: code = exc_s_call;
					default:         code = exc_m_call;
				endcase
			end
			else if (f_ebreak)
				code = exc_breakpoint;
		end
	end

	assign cause = {irq, {(xlen-6){1'b0}}, code};

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/10ps

module exe_stage #(parameter int xlen = 32)
(
	input  logic clk,
	input  logic nrst,
	input  logic [xlen-1:0] op_a,
	input  logic [xlen-1:0] op_b,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] b_imm,
	input  logic [xlen-1:0] j_imm,
	input  logic [xlen-1:0] u_imm,
	input  logic [4:0] rd,
	input  logic we,
	input  exe_isa_pkg::alu_op_t alu_op,
	input  exe_isa_pkg::br_cond_t br_cond,
	input  logic j,
	input  logic jr,
	input  exe_isa_pkg::wb_sel_t wb_sel,
	input  logic instr_misaligned,
	input  logic ecall,
	input  logic ebreak,
	input  logic illegal,
	input  logic m_timer,
	input  logic s_timer,
	input  logic u_timer,
	input  logic external_interrupt,
	input  exe_trap_pkg::priv_mode_t current_mode,
	input  logic m_tie,
	input  logic s_tie,
	input  logic u_tie,
	input  logic m_eie,
	input  logic s_eie,
	input  logic u_eie,
	output logic [xlen-1:0] target,
	output logic redirect,
	output logic [xlen-1:0] wb_data,
	output logic wb_we,
	output logic [4:0] wb_rd,
	output logic [xlen-1:0] pc_out,
	output logic exception,
	output logic [xlen-1:0] cause,
	output logic m_interrupt,
	output logic s_interrupt,
	output logic u_interrupt
);
	import exe_isa_pkg::*;

	// stage 5
	logic [xlen-1:0] s5_op_a, s5_op_b, s5_pc;
	logic [xlen-1:0] s5_b_imm, s5_j_imm, s5_u_imm;
	logic [4:0] s5_rd;
	logic s5_we, s5_j, s5_jr;
	alu_op_t s5_alu_op;
	br_cond_t s5_br_cond;
	wb_sel_t s5_wb_sel;
	logic s5_instr_misaligned, s5_ecall, s5_ebreak, s5_illegal;
	logic [xlen-1:0] alu_result;

	// stage 6 faults into the trap logic
	logic f_misaligned, f_ecall, f_ebreak, f_illegal;

	issue_stage #(.xlen(xlen)) u_issue
	(
		.clk(clk), .nrst(nrst), .flush(exception),
		.op_a(op_a), .op_b(op_b), .pc(pc),
		.b_imm(b_imm), .j_imm(j_imm), .u_imm(u_imm),
		.rd(rd), .we(we), .j(j), .jr(jr),
		.alu_op(alu_op), .br_cond(br_cond), .wb_sel(wb_sel),
		.instr_misaligned(instr_misaligned), .ecall(ecall),
		.ebreak(ebreak), .illegal(illegal),
		.s5_op_a(s5_op_a), .s5_op_b(s5_op_b), .s5_pc(s5_pc),
		.s5_b_imm(s5_b_imm), .s5_j_imm(s5_j_imm), .s5_u_imm(s5_u_imm),
		.s5_rd(s5_rd), .s5_we(s5_we), .s5_j(s5_j), .s5_jr(s5_jr),
		.s5_alu_op(s5_alu_op), .s5_br_cond(s5_br_cond), .s5_wb_sel(s5_wb_sel),
		.s5_instr_misaligned(s5_instr_misaligned), .s5_ecall(s5_ecall),
		.s5_ebreak(s5_ebreak), .s5_illegal(s5_illegal)
	);

	alu #(.xlen(xlen)) u_alu
	(
		.alu_op(s5_alu_op), .a(s5_op_a), .b(s5_op_b), .result(alu_result)
	);

	branch_unit #(.xlen(xlen)) u_branch
	(
		.br_cond(s5_br_cond), .j(s5_j), .jr(s5_jr),
		.pc(s5_pc), .a(s5_op_a), .b(s5_op_b),
		.b_imm(s5_b_imm), .j_imm(s5_j_imm),
		.target(target), .redirect(redirect)
	);

	commit_stage #(.xlen(xlen)) u_commit
	(
		.clk(clk), .nrst(nrst), .flush(exception),
		.alu_result(alu_result), .pc(s5_pc), .u_imm(s5_u_imm),
		.rd(s5_rd), .we(s5_we), .wb_sel(s5_wb_sel),
		.s5_instr_misaligned(s5_instr_misaligned), .s5_ecall(s5_ecall),
		.s5_ebreak(s5_ebreak), .s5_illegal(s5_illegal),
		.wb_data(wb_data), .pc_out(pc_out), .wb_rd(wb_rd), .wb_we(wb_we),
		.f_misaligned(f_misaligned), .f_ecall(f_ecall),
		.f_ebreak(f_ebreak), .f_illegal(f_illegal)
	);

	trap_unit #(.xlen(xlen)) u_trap
	(
		.f_misaligned(f_misaligned), .f_ecall(f_ecall),
		.f_ebreak(f_ebreak), .f_illegal(f_illegal),
		.current_mode(current_mode),
		.m_timer(m_timer), .s_timer(s_timer), .u_timer(u_timer),
		.external_interrupt(external_interrupt),
		.m_tie(m_tie), .s_tie(s_tie), .u_tie(u_tie),
		.m_eie(m_eie), .s_eie(s_eie), .u_eie(u_eie),
		.exception(exception), .cause(cause),
		.m_interrupt(m_interrupt), .s_interrupt(s_interrupt),
		.u_interrupt(u_interrupt)
	);

endmodule

// File: test/exe_tasks.svh
function automatic logic [31:0] alu_model(input alu_op_t op, input logic [31:0] a,
	input logic [31:0] b);
	int sa;
	int sb;
	logic [4:0] sh;
	sa = a;
	sb = b;
	sh = b[4:0];
	case (op)
		alu_add:  return a + b;
		alu_sub:  return a - b;
		alu_sll:  return a << sh;
		alu_slt:  return (sa < sb) ? 32'd1 : 32'd0;
		alu_sltu: return (a < b) ? 32'd1 : 32'd0;
		alu_xor:  return a ^ b;
		alu_srl:  return a >> sh;
		alu_sra:  return sa >>> sh; // int keeps the sign
		alu_or:   return a | b;
		alu_and:  return a & b;
		default:  return 32'd0;
	endcase
endfunction

function automatic logic cond_holds(input br_cond_t c, input logic [31:0] a,
	input logic [31:0] b);
	int sa;
	int sb;
	sa = a;
	sb = b;
	case (c)
		br_eq:   return a == b;
		br_ne:   return a != b;
		br_lt:   return sa < sb;
		br_ge:   return sa >= sb;
		br_ltu:  return a < b;
		br_geu:  return a >= b;
		default: return 1'b0;
	endcase
endfunction

task automatic report_error(input string msg);
	errors++;
	$display("ERROR at %0t ns: %s", $time, msg);
endtask

task automatic drive_idle();
	we <= 1'b0;
	{j, jr} <= 2'b00;
	br_cond <= br_none;
	alu_op <= alu_add;
	wb_sel <= wb_alu;
	{instr_misaligned, illegal, ecall, ebreak} <= 4'b0000;
endtask

task automatic init_inputs();
	nrst <= 1'b0;
	drive_idle();
	{op_a, op_b, pc} <= '0;
	{b_imm, j_imm, u_imm} <= '0;
	rd <= 5'd0;
	current_mode <= mode_machine;
	{m_timer, s_timer, u_timer, external_interrupt} <= 4'b0000;
	{m_tie, s_tie, u_tie, m_eie, s_eie, u_eie} <= 6'b000000;
endtask

task automatic drive_instr(input alu_op_t op, input wb_sel_t sel, input logic [31:0] a,
	input logic [31:0] b, input logic [31:0] p, input logic [31:0] u, input logic [4:0] r);
	drive_idle();
	we <= 1'b1;
	alu_op <= op;
	wb_sel <= sel;
	op_a <= a;
	op_b <= b;
	pc <= p;
	u_imm <= u;
	rd <= r;
endtask

task automatic check_reset();
	cases_run++;
	@(negedge clk);
	if ({wb_we, redirect, exception, m_interrupt, s_interrupt, u_interrupt} !== 6'b0)
		report_error("control outputs not idle after reset");
	if (cause !== 32'd0)
		report_error($sformatf("cause %h after reset, expected 0", cause));
endtask

// back-to-back issue with results two edges later
task automatic run_alu_stream();
	logic [31:0] exp_q [$];
	logic [31:0] pc_q [$];
	logic [4:0] rd_q [$];
	logic [31:0] a, b, p, u, want, exp_data, exp_pc;
	logic [4:0] r, exp_rd;
	alu_op_t op;
	wb_sel_t sel;
	int i;
	for (i = 0; i < 38; i++)
	begin
		@(posedge clk);
		a = $urandom;
		b = $urandom;
		p = $urandom & 32'hffff_fffc;
		u = $urandom & 32'hffff_f000; // upper immediate only
		r = 5'(i % 31 + 1);
		if (i < 30)
		begin
			op = alu_op_t'(4'(i % 10));
			drive_instr(op, wb_alu, a, b, p, u, r);
			exp_q.push_back(alu_model(op, a, b));
			pc_q.push_back(p);
			rd_q.push_back(r);
		end
		else if (i < 36)
		begin
			sel = wb_sel_t'(2'(1 + (i - 30) % 3));
			drive_instr(alu_sub, sel, a, b, p, u, r);
			case (sel)
				wb_pc_plus4: want = p + 32'd4;
				wb_lui:      want = u;
				default:     want = p + u;
			endcase
			exp_q.push_back(want);
			pc_q.push_back(p);
			rd_q.push_back(r);
		end
		else
			drive_idle(); // drain
		@(negedge clk);
		if (i >= 2)
		begin
			exp_data = exp_q.pop_front();
			exp_pc = pc_q.pop_front();
			exp_rd = rd_q.pop_front();
			cases_run++;
			if (wb_we !== 1'b1)
				report_error($sformatf("stream item %0d wb_we low", i - 2));
			if (wb_data !== exp_data)
				report_error($sformatf("stream item %0d wb_data %h, expected %h",
					i - 2, wb_data, exp_data));
			if (wb_rd !== exp_rd)
				report_error($sformatf("stream item %0d wb_rd %0d, expected %0d",
					i - 2, wb_rd, exp_rd));
			if (pc_out !== exp_pc)
				report_error($sformatf("stream item %0d pc_out %h, expected %h",
					i - 2, pc_out, exp_pc));
		end
	end
endtask

task automatic branch_case(input br_cond_t c, input logic jj, input logic jjr,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] p, bi, ji, exp_t;
	logic exp_r;
	p = $urandom & 32'hffff_fffc;
	bi = $urandom & 32'h0000_0ffe;
	ji = $urandom & 32'h000f_fffe;
	exp_r = jj | jjr | cond_holds(c, a, b);
	if (jjr)
		exp_t = (a + b) & 32'hffff_fffe;
	else if (jj)
		exp_t = p + ji;
	else if (exp_r)
		exp_t = p + bi;
	else
		exp_t = 32'd0;
	cases_run++;
	@(posedge clk);
	drive_idle();
	op_a <= a;
	op_b <= b;
	pc <= p;
	b_imm <= bi;
	j_imm <= ji;
	br_cond <= c;
	j <= jj;
	jr <= jjr;
	@(posedge clk);
	drive_idle();
	@(negedge clk);
	if (redirect !== exp_r)
		report_error($sformatf("%s j=%b jr=%b redirect %b, expected %b",
			c.name(), jj, jjr, redirect, exp_r));
	if (target !== exp_t)
		report_error($sformatf("%s j=%b jr=%b target %h, expected %h",
			c.name(), jj, jjr, target, exp_t));
endtask

task automatic run_branches();
	logic [31:0] pa [4];
	logic [31:0] pb [4];
	int c;
	int k;
	pa = '{32'd5, 32'd3, 32'hffff_fffd, 32'd7}; // equal, less, negative vs positive, greater
	pb = '{32'd5, 32'd7, 32'd7, 32'd3};
	for (c = 1; c <= 6; c++)
		for (k = 0; k < 4; k++)
			branch_case(br_cond_t'(3'(c)), 1'b0, 1'b0, pa[k], pb[k]);
	branch_case(br_none, 1'b0, 1'b0, 32'd5, 32'd5);
	branch_case(br_none, 1'b1, 1'b0, 32'd0, 32'd0);
	branch_case(br_none, 1'b0, 1'b1, 32'h0000_1235, 32'h0000_0010); // odd sum
endtask

task automatic fault_case(input string name, input priv_mode_t m, input logic [3:0] flags,
	input logic [31:0] want);
	cases_run++;
	@(posedge clk);
	drive_idle();
	current_mode <= m;
	pc <= 32'h0000_00f0;
	{instr_misaligned, illegal, ecall, ebreak} <= flags;
	@(posedge clk);
	drive_instr(alu_add, wb_alu, 32'd1, 32'd2, 32'h0000_0100, 32'd0, 5'd9); // follower
	@(posedge clk);
	drive_idle();
	@(negedge clk);
	if (exception !== 1'b1)
		report_error({name, ": no exception"});
	if (cause !== want)
		report_error($sformatf("%s: cause %h, expected %h", name, cause, want));
	@(negedge clk);
	if (exception !== 1'b0)
		report_error({name, ": exception held past one cycle"});
	if (wb_we !== 1'b0)
		report_error({name, ": instruction behind the fault wrote back"});
	if (pc_out !== 32'h0000_00f0)
		report_error($sformatf("%s: pc_out %h after the flush, expected 000000f0",
			name, pc_out));
endtask

task automatic run_faults();
	fault_case("misaligned", mode_machine, 4'b1000, 32'd0);
	fault_case("illegal", mode_machine, 4'b0100, 32'd2);
	fault_case("ebreak", mode_supervisor, 4'b0001, 32'd3);
	fault_case("ecall in user", mode_user, 4'b0010, 32'd8);
	fault_case("ecall in supervisor", mode_supervisor, 4'b0010, 32'd9);
	fault_case("ecall in machine", mode_machine, 4'b0010, 32'd11);
	fault_case("illegal with ecall", mode_user, 4'b0110, 32'd2);
endtask

// src bits are m/s/u timer, external, m/s/u tie, m/s/u eie
task automatic irq_case(input priv_mode_t m, input logic [9:0] src);
	logic below_m, user_m;
	logic mt, st, ut, me, se, ue, any;
	logic [4:0] code;
	logic [31:0] want;
	below_m = (m != mode_machine);
	user_m = (m == mode_user);
	mt = src[9] & src[5];
	st = src[8] & src[4] & below_m;
	ut = src[7] & src[3] & user_m;
	me = src[6] & src[2];
	se = src[6] & src[1] & below_m;
	ue = src[6] & src[0] & user_m;
	any = mt | st | ut | me | se | ue;
	if (me)
		code = 5'd11;
	else if (se)
		code = 5'd9;
	else if (mt)
		code = 5'd7;
	else if (st)
		code = 5'd5;
	else if (ue)
		code = 5'd8;
	else
		code = 5'd4;
	want = any ? {1'b1, 26'd0, code} : 32'd0;
	cases_run++;
	@(posedge clk);
	current_mode <= m;
	{m_timer, s_timer, u_timer, external_interrupt, m_tie, s_tie, u_tie, m_eie, s_eie, u_eie}
		<= src;
	@(negedge clk);
	if ({m_interrupt, s_interrupt, u_interrupt, exception} !== {me, se, ue, any})
		report_error($sformatf("mode %0d src %b: m/s/u/exc %b, expected %b", m, src,
			{m_interrupt, s_interrupt, u_interrupt, exception}, {me, se, ue, any}));
	if (cause !== want)
		report_error($sformatf("mode %0d src %b: cause %h, expected %h", m, src, cause, want));
endtask

task automatic run_interrupts();
	priv_mode_t m;
	logic [9:0] src;
	logic [31:0] rnd;
	int mi;
	int k;
	for (mi = 0; mi < 3; mi++)
	begin
		m = (mi == 2) ? mode_machine : priv_mode_t'(2'(mi));
		for (k = 0; k < 6; k++)
		begin
			src = '0;
			src[(k < 3) ? 9 - k : 6] = 1'b1; // source alone
			irq_case(m, src);
			src[5 - k] = 1'b1; // now with its enable
			irq_case(m, src);
		end
	end
	for (k = 0; k < 24; k++)
	begin
		rnd = $urandom;
		irq_case(priv_mode_t'(rnd[11:10]), rnd[9:0]);
	end
	irq_case(mode_machine, 10'd0);
endtask

task automatic check_irq_over_fault();
	cases_run++;
	@(posedge clk);
	drive_idle();
	current_mode <= mode_user;
	illegal <= 1'b1;
	@(posedge clk);
	drive_idle();
	@(posedge clk);
	{m_timer, m_tie} <= 2'b11; // rises just as the fault reaches stage 6
	@(negedge clk);
	if (exception !== 1'b1)
		report_error("interrupt over fault: no exception");
	if (cause !== 32'h8000_0007)
		report_error($sformatf("interrupt over fault: cause %h, expected 80000007", cause));
	@(posedge clk);
	{m_timer, m_tie} <= 2'b00;
	@(negedge clk);
	if (exception !== 1'b0 || cause !== 32'd0)
		report_error("interrupt over fault: fault still pending after the flush");
endtask

// File: test/exe_stage_tb.sv
`timescale 1ns/10ps

module exe_stage_tb;
	import exe_isa_pkg::*;
	import exe_trap_pkg::*;

	localparam int xlen = 32;
	localparam int period = 20;
	localparam int seed_value = 32'h37fb_4376;
	// reset, alu/wb stream, branches, faults, interrupts, interrupt over fault
	localparam int test_cycles = 3 + 38 + 27 * 2 + 7 * 4 + 61 + 4;

	logic clk;
	logic nrst;
	logic [xlen-1:0] op_a, op_b, pc, b_imm, j_imm, u_imm;
	logic [4:0] rd;
	logic we, j, jr;
	alu_op_t alu_op;
	br_cond_t br_cond;
	wb_sel_t wb_sel;
	logic instr_misaligned, ecall, ebreak, illegal;
	logic m_timer, s_timer, u_timer, external_interrupt;
	priv_mode_t current_mode;
	logic m_tie, s_tie, u_tie, m_eie, s_eie, u_eie;
	logic [xlen-1:0] target, wb_data, pc_out, cause;
	logic redirect, wb_we, exception;
	logic [4:0] wb_rd;
	logic m_interrupt, s_interrupt, u_interrupt;

	int errors;
	int cases_run;

	exe_stage #(.xlen(xlen)) DUT (.*);

	`include "exe_tasks.svh"

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// watchdog at twice the expected run length
	initial
	begin
		#(test_cycles * period * 2);
		$display("Timeout: the tests did not finish within %0d ns", test_cycles * period * 2);
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		int rnd;
		errors = 0;
		cases_run = 0;
		rnd = $urandom(seed_value); // single seeding for the whole run
		init_inputs();
		repeat (2) @(posedge clk);
		nrst <= 1'b1;
		check_reset();
		run_alu_stream();
		run_branches();
		run_faults();
		run_interrupts();
		check_irq_over_fault();
		$display("%0d cases run, %0d errors", cases_run, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+test
logic/exe_isa_pkg.sv
logic/exe_trap_pkg.sv
logic/issue_stage.sv
logic/alu.sv
logic/branch_unit.sv
logic/commit_stage.sv
logic/trap_unit.sv
logic/exe_stage.sv
test/exe_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module exe_stage_tb -o exe_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/exe_sim | tee /dev/stderr | grep -q "^Regression passed$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
